//--- letc_top.f
rtl/letc_pkg.sv
rtl/letc_bus_arbiter.sv
rtl/letc_bus_decoder.sv
rtl/letc_sram.sv
rtl/letc_gpio.sv
rtl/letc_timer.sv
rtl/letc_top.sv
verification/letc_tb.sv

//--- verification/letc_tb.sv
// --------------------
// LETC subsystem testbench
// Drives both manager ports, checks responses,
// arbitration, GPIO pins and the timer interrupt
// --------------------

module letc_tb;

    localparam int SRAM_WORDS     = 256;
    localparam int TIMER_PRESCALE = 4;
    localparam int CLK_HALF       = 10;
    localparam int DRIVE_DLY      = 2;
    localparam int RAM_OPS        = 24;
    localparam int ARB_OPS        = 8;
    localparam int TIMER_CMP      = 6;
    // Three cycles per transfer at worst plus the waits
    localparam int WORST_CYCLES   = 10 + 3 * (2 * RAM_OPS + 8) + 3 * 12 + 3 * 2 * ARB_OPS
                                    + 3 * 8 + (TIMER_CMP + 6) * TIMER_PRESCALE;

    // rdata only compared when chk is set
    typedef struct packed {
        logic               chk;
        letc_pkg::bus_rsp_t rsp;
    } exp_t;

    logic i_clk = 1'b0;
    logic i_arst_n;
    logic i_core_req_valid, o_core_req_ready, o_core_rsp_valid;
    logic i_ps_req_valid, o_ps_req_ready, o_ps_rsp_valid;
    letc_pkg::bus_req_t i_core_req, i_ps_req;
    letc_pkg::bus_rsp_t o_core_rsp, o_ps_rsp, ps_rsp;
    logic [1:0] i_btn;
    logic o_led0_r, o_led0_g, o_led0_b, o_led1_r, o_led1_g, o_led1_b;
    logic [7:0] o_debug;
    logic o_timer_irq_pending;
    logic [5:0] leds;
    logic [18:0] ctrl_outs;

    logic [31:0] seed;
    logic [31:0] shadow [SRAM_WORDS];
    bit written [SRAM_WORDS];
    exp_t core_q[$], ps_q[$];
    exp_t core_head, ps_head;
    logic seen_req = 1'b0;
    letc_pkg::requester_e last_acc;
    int err_count = 0, errs_at_start = 0, tests_passed = 0, tests_failed = 0;

    assign leds = {o_led1_b, o_led1_g, o_led1_r, o_led0_b, o_led0_g, o_led0_r};
    assign ctrl_outs = {o_core_req_ready, o_ps_req_ready, o_core_rsp_valid, o_ps_rsp_valid,
                        leds, o_debug, o_timer_irq_pending};

    letc_top #(.SRAM_WORDS(SRAM_WORDS), .TIMER_PRESCALE(TIMER_PRESCALE)) letc_top_i (.*);

    always #CLK_HALF i_clk = ~i_clk;

    task automatic value_error(input string sig, input logic [32:0] want, input logic [32:0] act);
        err_count++;
        $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, sig, want, act);
    endtask

    task automatic other_error(input string msg);
        err_count++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        if (err_count == errs_at_start) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - errs_at_start);
        end
        errs_at_start = err_count;
    endtask

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic letc_pkg::bus_req_t make_req(input letc_pkg::bus_op_e op,
                                                    input logic [15:0] addr,
                                                    input logic [31:0] wdata);
        letc_pkg::bus_req_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    function automatic exp_t expect_rsp(input logic chk, input logic err, input logic [31:0] rdata);
        exp_t e;
        e.chk       = chk;
        e.rsp.err   = err;
        e.rsp.rdata = rdata;
        return e;
    endfunction

    function automatic logic rsp_ok(input letc_pkg::bus_rsp_t act, input exp_t want);
        return (act.err == want.rsp.err) && (!want.chk || act.rdata == want.rsp.rdata);
    endfunction

    // Somewhere in regions 3 to 15
    function automatic logic [15:0] unmapped_addr();
        logic [31:0] r;
        r = next_rand();
        return {4'(32'd3 + r[31:16] % 32'd13), r[11:2], 2'b00};
    endfunction

    // Valid stays high after acceptance unless last is set
    task automatic core_xfer(input letc_pkg::bus_req_t req, input exp_t want, input bit last);
        logic acc;
        acc = 1'b0;
        seen_req = 1'b1;
        i_core_req_valid = 1'b1;
        i_core_req = req;
        while (!acc) begin
            @(negedge i_clk);
            acc = o_core_req_ready;
            if (acc) begin
                core_q.push_back(want);
            end
            @(posedge i_clk);
            #DRIVE_DLY;
        end
        if (last) begin
            i_core_req_valid = 1'b0;
            @(posedge i_clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic ps_xfer(input letc_pkg::bus_req_t req, input exp_t want, input bit last);
        logic acc;
        acc = 1'b0;
        seen_req = 1'b1;
        i_ps_req_valid = 1'b1;
        i_ps_req = req;
        while (!acc) begin
            @(negedge i_clk);
            acc = o_ps_req_ready;
            if (acc) begin
                ps_q.push_back(want);
            end
            @(posedge i_clk);
            #DRIVE_DLY;
        end
        if (last) begin
            i_ps_req_valid = 1'b0;
            @(negedge i_clk);
            ps_rsp = o_ps_rsp;
            @(posedge i_clk);
            #DRIVE_DLY;
        end
    endtask

    // Expected response for the cycle in progress
    always @(negedge i_clk) begin
        if (o_core_rsp_valid) begin
            if (core_q.size() == 0) begin
                other_error("core response with no request pending");
            end else begin
                core_head = core_q.pop_front();
            end
        end
        if (o_ps_rsp_valid) begin
            if (ps_q.size() == 0) begin
                other_error("PS response with no request pending");
            end else begin
                ps_head = ps_q.pop_front();
            end
        end
    end

    // Round-robin reference of the last accepted manager
    always @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            last_acc <= letc_pkg::REQ_PS;
        end else if (o_core_req_ready) begin
            last_acc <= letc_pkg::REQ_CORE;
        end else if (o_ps_req_ready) begin
            last_acc <= letc_pkg::REQ_PS;
        end
    end

    a_core_rsp: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $past(o_core_req_ready) == o_core_rsp_valid)
        else other_error("core response not exactly one cycle after acceptance");
    a_ps_rsp: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $past(o_ps_req_ready) == o_ps_rsp_valid)
        else other_error("PS response not exactly one cycle after acceptance");

    a_core_data: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_core_rsp_valid |-> rsp_ok(o_core_rsp, core_head))
        else value_error("o_core_rsp", $sampled(core_head.rsp), $sampled(o_core_rsp));
    a_ps_data: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_ps_rsp_valid |-> rsp_ok(o_ps_rsp, ps_head))
        else value_error("o_ps_rsp", $sampled(ps_head.rsp), $sampled(o_ps_rsp));

    a_idle_low: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !seen_req |-> ctrl_outs == '0)
        else value_error("control outputs", '0, $sampled(ctrl_outs));

    a_round_robin: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_core_req_valid && i_ps_req_valid
        |-> (last_acc == letc_pkg::REQ_PS ? o_core_req_ready : o_ps_req_ready))
        else other_error("tie not granted to the manager that waited longer");

    initial begin
        int off;
        int wait_cycles;
        logic [31:0] data;
        logic [7:0] dbg;
        exp_t wr_ok;
        exp_t bad;
        wr_ok = expect_rsp(1'b0, 1'b0, '0);
        bad   = expect_rsp(1'b1, 1'b1, letc_pkg::BAD_ADDR_DATA);
        seed = 32'h87b2;
        i_arst_n = 1'b0;
        i_core_req_valid = 1'b0;
        i_core_req = '0;
        i_ps_req_valid = 1'b0;
        i_ps_req = '0;
        i_btn = 2'b00;
        repeat (4) @(posedge i_clk);
        #DRIVE_DLY;
        i_arst_n = 1'b1;

        // Idle outputs covered by a_idle_low
        repeat (5) @(posedge i_clk);
        #DRIVE_DLY;
        end_test("reset state");

        // Core fills the RAM and PS reads it back
        for (int i = 0; i < RAM_OPS; i++) begin
            off = int'(next_rand() % SRAM_WORDS);
            data = next_rand();
            shadow[off] = data;
            written[off] = 1'b1;
            core_xfer(make_req(letc_pkg::BUS_WRITE, 16'(off * 4), data), wr_ok, i == RAM_OPS - 1);
        end
        for (int i = 0; i < SRAM_WORDS; i++) begin
            if (written[i]) begin
                ps_xfer(make_req(letc_pkg::BUS_READ, 16'(i * 4), '0),
                        expect_rsp(1'b1, 1'b0, shadow[i]), 1'b0);
            end
        end
        ps_xfer(make_req(letc_pkg::BUS_READ, 16'((SRAM_WORDS + off) * 4), '0), bad, 1'b0);
        ps_xfer(make_req(letc_pkg::BUS_READ, unmapped_addr(), '0), bad, 1'b1);
        // Past the array would alias off without the range check
        core_xfer(make_req(letc_pkg::BUS_WRITE, 16'((SRAM_WORDS + off) * 4), ~shadow[off]),
                  bad, 1'b0);
        core_xfer(make_req(letc_pkg::BUS_WRITE, unmapped_addr(), next_rand()), bad, 1'b1);
        ps_xfer(make_req(letc_pkg::BUS_READ, 16'(off * 4), '0),
                expect_rsp(1'b1, 1'b0, shadow[off]), 1'b1);
        end_test("ram");

        // LED and debug registers, then buttons
        data = next_rand();
        dbg = data[15:8];
        core_xfer(make_req(letc_pkg::BUS_WRITE, {letc_pkg::REGION_GPIO, letc_pkg::GPIO_LED}, data),
                  wr_ok, 1'b0);
        core_xfer(make_req(letc_pkg::BUS_WRITE, {letc_pkg::REGION_GPIO, letc_pkg::GPIO_DEBUG},
                           {24'b0, dbg}), wr_ok, 1'b1);
        assert ({leds, o_debug} == {data[5:0], dbg})
            else value_error("LED and debug pins", {data[5:0], dbg}, {leds, o_debug});
        ps_xfer(make_req(letc_pkg::BUS_READ, {letc_pkg::REGION_GPIO, letc_pkg::GPIO_LED}, '0),
                expect_rsp(1'b1, 1'b0, {26'b0, data[5:0]}), 1'b0);
        ps_xfer(make_req(letc_pkg::BUS_READ, {letc_pkg::REGION_GPIO, letc_pkg::GPIO_DEBUG}, '0),
                expect_rsp(1'b1, 1'b0, {24'b0, dbg}), 1'b1);
        for (int b = 1; b < 4; b++) begin
            i_btn = 2'(b);
            repeat (3) @(posedge i_clk);
            #DRIVE_DLY;
            ps_xfer(make_req(letc_pkg::BUS_READ, {letc_pkg::REGION_GPIO, letc_pkg::GPIO_BTN}, '0),
                    expect_rsp(1'b1, 1'b0, 32'(b)), 1'b1);
        end
        end_test("gpio");

        // Both ports busy so grants must alternate
        fork
            for (int i = 0; i < ARB_OPS; i++) begin
                off = int'(next_rand() % SRAM_WORDS);
                data = next_rand();
                shadow[off] = data;
                core_xfer(make_req(letc_pkg::BUS_WRITE, 16'(off * 4), data), wr_ok,
                          i == ARB_OPS - 1);
            end
            for (int j = 0; j < ARB_OPS; j++) begin
                ps_xfer(make_req(letc_pkg::BUS_READ,
                                 {letc_pkg::REGION_GPIO, letc_pkg::GPIO_DEBUG}, '0),
                        expect_rsp(1'b1, 1'b0, {24'b0, dbg}), j == ARB_OPS - 1);
            end
        join
        end_test("arbitration");

        // Compare already true but the timer is off
        core_xfer(make_req(letc_pkg::BUS_WRITE, {letc_pkg::REGION_TIMER, letc_pkg::TIMER_MTIMECMP},
                           '0), wr_ok, 1'b1);
        repeat (4 * TIMER_PRESCALE) begin
            @(negedge i_clk);
            assert (!o_timer_irq_pending)
                else other_error("timer interrupt high while the timer is disabled");
        end
        @(posedge i_clk);
        #DRIVE_DLY;
        core_xfer(make_req(letc_pkg::BUS_WRITE, {letc_pkg::REGION_TIMER, letc_pkg::TIMER_MTIME},
                           '0), wr_ok, 1'b0);
        core_xfer(make_req(letc_pkg::BUS_WRITE, {letc_pkg::REGION_TIMER, letc_pkg::TIMER_MTIMECMP},
                           32'(TIMER_CMP)), wr_ok, 1'b0);
        core_xfer(make_req(letc_pkg::BUS_WRITE, {letc_pkg::REGION_TIMER, letc_pkg::TIMER_CTRL},
                           32'd1), wr_ok, 1'b1);
        wait_cycles = 0;
        while (!o_timer_irq_pending && wait_cycles < (TIMER_CMP + 2) * TIMER_PRESCALE) begin
            @(negedge i_clk);
            wait_cycles++;
        end
        assert (o_timer_irq_pending)
            else other_error("timer interrupt did not rise in time");
        @(posedge i_clk);
        #DRIVE_DLY;
        ps_xfer(make_req(letc_pkg::BUS_READ, {letc_pkg::REGION_TIMER, letc_pkg::TIMER_MTIME}, '0),
                wr_ok, 1'b1);
        assert (ps_rsp.rdata >= TIMER_CMP)
            else value_error("mtime lower bound", 33'(TIMER_CMP), 33'(ps_rsp.rdata));
        core_xfer(make_req(letc_pkg::BUS_WRITE, {letc_pkg::REGION_TIMER, letc_pkg::TIMER_MTIMECMP},
                           '1), wr_ok, 1'b1);
        assert (!o_timer_irq_pending)
            else other_error("timer interrupt still high after mtimecmp set to all ones");
        end_test("timer");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Four times the summed worst case
    initial begin
        #(WORST_CYCLES * 4 * 2 * CLK_HALF);
        $display("Watchdog expired before the tests completed");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule : letc_tb

//--- rtl/letc_top.sv
// --------------------
// LETC memory-mapped subsystem
// Two managers share the peripheral bus through an
// arbiter; a decoder routes each request to the RAM,
// the GPIO block or the machine timer
// --------------------

module letc_top #(
    parameter int SRAM_WORDS     = 256,
    parameter int TIMER_PRESCALE = 4
) (
    input  logic                i_clk,
    input  logic                i_arst_n,

    // Core load/store port
    input  logic                i_core_req_valid,
    input  letc_pkg::bus_req_t  i_core_req,
    output logic                o_core_req_ready,
    output logic                o_core_rsp_valid,
    output letc_pkg::bus_rsp_t  o_core_rsp,

    // PS manager port
    input  logic                i_ps_req_valid,
    input  letc_pkg::bus_req_t  i_ps_req,
    output logic                o_ps_req_ready,
    output logic                o_ps_rsp_valid,
    output letc_pkg::bus_rsp_t  o_ps_rsp,

    // Board pins
    input  logic [1:0]          i_btn,
    output logic                o_led0_r,
    output logic                o_led0_g,
    output logic                o_led0_b,
    output logic                o_led1_r,
    output logic                o_led1_g,
    output logic                o_led1_b,
    output logic [7:0]          o_debug,

    // To the core timer interrupt input
    output logic                o_timer_irq_pending
);

    logic                                sel_valid;
    letc_pkg::bus_req_t                  sel_req;
    logic                                rsp_valid;
    letc_pkg::bus_rsp_t                  rsp;
    logic                                sram_sel;
    logic                                gpio_sel;
    logic                                timer_sel;
    letc_pkg::bus_op_e                   op;
    logic [letc_pkg::WORD_ADDR_W-1:0]    word_addr;
    logic [letc_pkg::DATA_W-1:0]         wdata;
    logic [letc_pkg::DATA_W-1:0]         sram_rdata;
    logic [letc_pkg::DATA_W-1:0]         gpio_rdata;
    logic [letc_pkg::DATA_W-1:0]         timer_rdata;

    letc_bus_arbiter arbiter_i (
        .i_clk, .i_arst_n,
        .i_core_req_valid, .i_core_req, .o_core_req_ready, .o_core_rsp_valid, .o_core_rsp,
        .i_ps_req_valid, .i_ps_req, .o_ps_req_ready, .o_ps_rsp_valid, .o_ps_rsp,
        .o_sel_valid(sel_valid), .o_sel_req(sel_req),
        .i_rsp_valid(rsp_valid), .i_rsp(rsp)
    );

    letc_bus_decoder #(.SRAM_WORDS(SRAM_WORDS)) decoder_i (
        .i_clk, .i_arst_n,
        .i_sel_valid(sel_valid), .i_sel_req(sel_req),
        .o_sram_sel(sram_sel), .o_gpio_sel(gpio_sel), .o_timer_sel(timer_sel),
        .o_op(op), .o_word_addr(word_addr), .o_wdata(wdata),
        .i_sram_rdata(sram_rdata), .i_gpio_rdata(gpio_rdata), .i_timer_rdata(timer_rdata),
        .o_rsp_valid(rsp_valid), .o_rsp(rsp)
    );

    letc_sram #(.SRAM_WORDS(SRAM_WORDS)) sram_i (
        .i_clk, .i_sel(sram_sel), .i_op(op), .i_word_addr(word_addr),
        .i_wdata(wdata), .o_rdata(sram_rdata)
    );

    // LED bits run led1 b,g,r then led0 b,g,r from the top
    letc_gpio gpio_i (
        .i_clk, .i_arst_n, .i_sel(gpio_sel), .i_op(op), .i_word_addr(word_addr),
        .i_wdata(wdata), .i_btn, .o_rdata(gpio_rdata),
        .o_led({o_led1_b, o_led1_g, o_led1_r, o_led0_b, o_led0_g, o_led0_r}),
        .o_debug
    );

    letc_timer #(.TIMER_PRESCALE(TIMER_PRESCALE)) timer_i (
        .i_clk, .i_arst_n, .i_sel(timer_sel), .i_op(op), .i_word_addr(word_addr),
        .i_wdata(wdata), .o_rdata(timer_rdata), .o_irq_pending(o_timer_irq_pending)
    );

endmodule : letc_top

//--- rtl/letc_timer.sv
// --------------------
// LETC machine timer
// Prescaled mtime counter, compare register and
// the registered timer interrupt
// --------------------

module letc_timer #(
    parameter int TIMER_PRESCALE = 4
) (
    input  logic                                i_clk,
    input  logic                                i_arst_n,
    input  logic                                i_sel,
    input  letc_pkg::bus_op_e                   i_op,
    input  logic [letc_pkg::WORD_ADDR_W-1:0]    i_word_addr,
    input  logic [letc_pkg::DATA_W-1:0]         i_wdata,
    output logic [letc_pkg::DATA_W-1:0]         o_rdata,
    output logic                                o_irq_pending
);

    localparam int PW = (TIMER_PRESCALE > 1) ? $clog2(TIMER_PRESCALE) : 1;

    logic [letc_pkg::OFFSET_W-1:0] offset;
    logic                          wr;
    logic [PW-1:0]                 pre_q, pre_d;
    logic [letc_pkg::DATA_W-1:0]   mtime_q, mtime_d;
    logic [letc_pkg::DATA_W-1:0]   cmp_q, cmp_d;
    logic                          en_q, en_d;

    assign offset = {i_word_addr, 2'b00};
    assign wr     = i_sel && (i_op == letc_pkg::BUS_WRITE);

    always_comb begin
        pre_d   = '0;
        mtime_d = mtime_q;
        cmp_d   = cmp_q;
        en_d    = en_q;
        // Count one mtime tick per prescale period
        if (en_q) begin
            if (pre_q == PW'(TIMER_PRESCALE - 1)) begin
                mtime_d = mtime_q + 32'd1;
            end else begin
                pre_d = pre_q + PW'(1);
            end
        end
        // Bus writes win over the count
        if (wr) begin
            case (offset)
                letc_pkg::TIMER_MTIME:    mtime_d = i_wdata;
                letc_pkg::TIMER_MTIMECMP: cmp_d   = i_wdata;
                letc_pkg::TIMER_CTRL:     en_d    = i_wdata[0];
                default:                  ;
            endcase
        end
    end

    // Interrupt follows the next register values, so it matches them every cycle
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pre_q         <= '0;
            mtime_q       <= '0;
            cmp_q         <= '1;
            en_q          <= 1'b0;
            o_irq_pending <= 1'b0;
        end else begin
            pre_q         <= pre_d;
            mtime_q       <= mtime_d;
            cmp_q         <= cmp_d;
            en_q          <= en_d;
            o_irq_pending <= en_d && (mtime_d >= cmp_d);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_sel) begin
            case (offset)
                letc_pkg::TIMER_MTIME:    o_rdata <= mtime_q;
                letc_pkg::TIMER_MTIMECMP: o_rdata <= cmp_q;
                letc_pkg::TIMER_CTRL:     o_rdata <= {31'b0, en_q};
                default:                  o_rdata <= '0;
            endcase
        end
    end

    a_irq_needs_en: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !en_q |-> !o_irq_pending);

endmodule : letc_timer

//--- rtl/letc_gpio.sv
// --------------------
// LETC GPIO
// LED and debug output registers, plus a
// synchronized button input register
// --------------------

module letc_gpio (
    input  logic                                i_clk,
    input  logic                                i_arst_n,
    input  logic                                i_sel,
    input  letc_pkg::bus_op_e                   i_op,
    input  logic [letc_pkg::WORD_ADDR_W-1:0]    i_word_addr,
    input  logic [letc_pkg::DATA_W-1:0]         i_wdata,
    input  logic [1:0]                          i_btn,
    output logic [letc_pkg::DATA_W-1:0]         o_rdata,
    output logic [5:0]                          o_led,
    output logic [7:0]                          o_debug
);

    logic [letc_pkg::OFFSET_W-1:0] offset;
    logic                          wr;
    logic [1:0]                    btn_meta_q;
    logic [1:0]                    btn_sync_q;

    assign offset = {i_word_addr, 2'b00};
    assign wr     = i_sel && (i_op == letc_pkg::BUS_WRITE);

    // Button writes fall through, the register is read-only
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_led   <= '0;
            o_debug <= '0;
        end else if (wr) begin
            if (offset == letc_pkg::GPIO_LED) begin
                o_led <= i_wdata[5:0];
            end
            if (offset == letc_pkg::GPIO_DEBUG) begin
                o_debug <= i_wdata[7:0];
            end
        end
    end

    // Two flop synchronizer for the asynchronous buttons
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            btn_meta_q <= '0;
            btn_sync_q <= '0;
        end else begin
            btn_meta_q <= i_btn;
            btn_sync_q <= btn_meta_q;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_sel) begin
            case (offset)
                letc_pkg::GPIO_LED:   o_rdata <= {26'b0, o_led};
                letc_pkg::GPIO_DEBUG: o_rdata <= {24'b0, o_debug};
                letc_pkg::GPIO_BTN:   o_rdata <= {30'b0, btn_sync_q};
                default:              o_rdata <= '0;
            endcase
        end
    end

endmodule : letc_gpio

//--- rtl/letc_sram.sv
// --------------------
// LETC scratch RAM
// Word array with a registered read port
// --------------------

module letc_sram #(
    parameter int SRAM_WORDS = 256
) (
    input  logic                                i_clk,
    input  logic                                i_sel,
    input  letc_pkg::bus_op_e                   i_op,
    input  logic [letc_pkg::WORD_ADDR_W-1:0]    i_word_addr,
    input  logic [letc_pkg::DATA_W-1:0]         i_wdata,
    output logic [letc_pkg::DATA_W-1:0]         o_rdata
);

    localparam int AW = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

    logic [letc_pkg::DATA_W-1:0] mem [SRAM_WORDS];
    logic [AW-1:0]               idx;

    // Decoder keeps the offset inside the array
    assign idx = i_word_addr[AW-1:0];

    always_ff @(posedge i_clk) begin
        if (i_sel) begin
            if (i_op == letc_pkg::BUS_WRITE) begin
                mem[idx] <= i_wdata;
            end
            // Old contents on a write cycle
            o_rdata <= mem[idx];
        end
    end

endmodule : letc_sram

//--- rtl/letc_bus_decoder.sv
// --------------------
// LETC bus decoder
// Selects one subordinate from the address, then
// builds the response from its read data or the
// error value for unmapped addresses
// --------------------

module letc_bus_decoder #(
    parameter int SRAM_WORDS = 256
) (
    input  logic                                i_clk,
    input  logic                                i_arst_n,

    input  logic                                i_sel_valid,
    input  letc_pkg::bus_req_t                  i_sel_req,

    output logic                                o_sram_sel,
    output logic                                o_gpio_sel,
    output logic                                o_timer_sel,
    output letc_pkg::bus_op_e                   o_op,
    output logic [letc_pkg::WORD_ADDR_W-1:0]    o_word_addr,
    output logic [letc_pkg::DATA_W-1:0]         o_wdata,

    input  logic [letc_pkg::DATA_W-1:0]         i_sram_rdata,
    input  logic [letc_pkg::DATA_W-1:0]         i_gpio_rdata,
    input  logic [letc_pkg::DATA_W-1:0]         i_timer_rdata,

    output logic                                o_rsp_valid,
    output letc_pkg::bus_rsp_t                  o_rsp
);

    logic [letc_pkg::REGION_W-1:0] region;
    logic [letc_pkg::REGION_W-1:0] region_q;
    logic                          err_q;
    logic                          rsp_valid_q;

    assign region      = i_sel_req.addr[15:12];
    assign o_word_addr = i_sel_req.addr[11:2];
    assign o_op        = i_sel_req.op;
    assign o_wdata     = i_sel_req.wdata;

    // RAM offsets past the array count as unmapped
    assign o_sram_sel  = i_sel_valid && (region == letc_pkg::REGION_SRAM)
                         && (32'(o_word_addr) < SRAM_WORDS);
    assign o_gpio_sel  = i_sel_valid && (region == letc_pkg::REGION_GPIO);
    assign o_timer_sel = i_sel_valid && (region == letc_pkg::REGION_TIMER);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rsp_valid_q <= 1'b0;
            region_q    <= '0;
            err_q       <= 1'b0;
        end else begin
            rsp_valid_q <= i_sel_valid;
            region_q    <= region;
            err_q       <= i_sel_valid && !(o_sram_sel || o_gpio_sel || o_timer_sel);
        end
    end

    // Subordinate data lines up with the registered region
    always_comb begin
        o_rsp.err = err_q;
        if (err_q) begin
            o_rsp.rdata = letc_pkg::BAD_ADDR_DATA;
        end else begin
            case (region_q)
                letc_pkg::REGION_GPIO:  o_rsp.rdata = i_gpio_rdata;
                letc_pkg::REGION_TIMER: o_rsp.rdata = i_timer_rdata;
                default:                o_rsp.rdata = i_sram_rdata;
            endcase
        end
    end

    assign o_rsp_valid = rsp_valid_q;

    a_sel_onehot: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0({o_sram_sel, o_gpio_sel, o_timer_sel}));

endmodule : letc_bus_decoder

//--- rtl/letc_bus_arbiter.sv
// --------------------
// LETC bus arbiter
// Round-robin sharing of the peripheral bus between
// the core and PS managers, with response steering
// back to the manager that owns each transfer
// --------------------

module letc_bus_arbiter (
    input  logic                i_clk,
    input  logic                i_arst_n,

    input  logic                i_core_req_valid,
    input  letc_pkg::bus_req_t  i_core_req,
    output logic                o_core_req_ready,
    output logic                o_core_rsp_valid,
    output letc_pkg::bus_rsp_t  o_core_rsp,

    input  logic                i_ps_req_valid,
    input  letc_pkg::bus_req_t  i_ps_req,
    output logic                o_ps_req_ready,
    output logic                o_ps_rsp_valid,
    output letc_pkg::bus_rsp_t  o_ps_rsp,

    output logic                o_sel_valid,
    output letc_pkg::bus_req_t  o_sel_req,

    input  logic                i_rsp_valid,
    input  letc_pkg::bus_rsp_t  i_rsp
);

    letc_pkg::requester_e grant;
    letc_pkg::requester_e last_grant_q;
    letc_pkg::requester_e rsp_owner_q;

    // Tie goes to whoever was not granted last
    always_comb begin
        if (i_core_req_valid && i_ps_req_valid) begin
            grant = (last_grant_q == letc_pkg::REQ_PS) ? letc_pkg::REQ_CORE
                                                       : letc_pkg::REQ_PS;
        end else if (i_core_req_valid) begin
            grant = letc_pkg::REQ_CORE;
        end else begin
            grant = letc_pkg::REQ_PS;
        end
    end

    // Subordinates never stall, so any valid request is taken
    assign o_sel_valid      = i_core_req_valid || i_ps_req_valid;
    assign o_sel_req        = (grant == letc_pkg::REQ_CORE) ? i_core_req : i_ps_req;
    assign o_core_req_ready = i_core_req_valid && (grant == letc_pkg::REQ_CORE);
    assign o_ps_req_ready   = i_ps_req_valid && (grant == letc_pkg::REQ_PS);

    // Remember the owner for the response one cycle later
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            last_grant_q <= letc_pkg::REQ_PS;
            rsp_owner_q  <= letc_pkg::REQ_CORE;
        end else if (o_sel_valid) begin
            last_grant_q <= grant;
            rsp_owner_q  <= grant;
        end
    end

    // Response data is shared, only the valid is steered
    assign o_core_rsp_valid = i_rsp_valid && (rsp_owner_q == letc_pkg::REQ_CORE);
    assign o_ps_rsp_valid   = i_rsp_valid && (rsp_owner_q == letc_pkg::REQ_PS);
    assign o_core_rsp       = i_rsp;
    assign o_ps_rsp         = i_rsp;

    // One manager granted per cycle
    a_one_ready: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(o_core_req_ready && o_ps_req_ready));

    // A stalled manager keeps its request until accepted
    a_core_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_core_req_valid && !o_core_req_ready |=> i_core_req_valid && $stable(i_core_req));
    a_ps_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_ps_req_valid && !o_ps_req_ready |=> i_ps_req_valid && $stable(i_ps_req));

endmodule : letc_bus_arbiter

//--- rtl/letc_pkg.sv
// --------------------
// LETC shared definitions
// Bus request and response structs, bus enums,
// address map and register offsets
// --------------------

package letc_pkg;

    // Data and address widths
    localparam int DATA_W      = 32;
    localparam int ADDR_W      = 16;
    localparam int WORD_ADDR_W = 10;
    localparam int REGION_W    = 4;
    localparam int OFFSET_W    = 12;

    // Transfer direction
    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_op_e;

    // Owner of a transaction
    typedef enum logic {
        REQ_CORE = 1'b0,
        REQ_PS   = 1'b1
    } requester_e;

    // Request from a manager, 49 bits
    typedef struct packed {
        bus_op_e            op;
        logic [ADDR_W-1:0]  addr;
        logic [DATA_W-1:0]  wdata;
    } bus_req_t;

    // Response back to a manager, 33 bits
    typedef struct packed {
        logic [DATA_W-1:0]  rdata;
        logic               err;
    } bus_rsp_t;

    // 4 KiB regions, selected by addr[15:12]
    localparam logic [REGION_W-1:0] REGION_SRAM  = 4'h0;
    localparam logic [REGION_W-1:0] REGION_GPIO  = 4'h1;
    localparam logic [REGION_W-1:0] REGION_TIMER = 4'h2;

    // GPIO register byte offsets
    localparam logic [OFFSET_W-1:0] GPIO_LED   = 12'h000;
    localparam logic [OFFSET_W-1:0] GPIO_DEBUG = 12'h004;
    localparam logic [OFFSET_W-1:0] GPIO_BTN   = 12'h008;

    // Timer register byte offsets
    localparam logic [OFFSET_W-1:0] TIMER_MTIME    = 12'h000;
    localparam logic [OFFSET_W-1:0] TIMER_MTIMECMP = 12'h004;
    localparam logic [OFFSET_W-1:0] TIMER_CTRL     = 12'h008;

    // Read value for unmapped addresses
    localparam logic [DATA_W-1:0] BAD_ADDR_DATA = 32'hDEAD_BEEF;

endpackage : letc_pkg
